//--- common/rename_pkg.sv
// rename sizes and ring helpers; tags run 1..rob_size with 0 meaning no producer
`default_nettype none

package rename_pkg;

    // architectural register file
    localparam int num_arch_regs  = 32;
    localparam int arch_idx_width = 5;

    // hard-wired zero register, never renamed
    localparam int zero_reg = 0;

    // reorder buffer tags
    localparam int rob_size      = 8;
    localparam int rob_tag_width = 4;

    // control states
    typedef enum logic {
        run,
        squash
    } rename_state_e;

    // successor of a tag in ring order, wraps from rob_size back to 1
    function automatic logic [rob_tag_width-1:0] next_tag(
        input logic [rob_tag_width-1:0] tag
    );
        if (tag == rob_tag_width'(rob_size)) begin
            return rob_tag_width'(1);
        end
        return tag + rob_tag_width'(1);
    endfunction

    // number of forward steps from from_tag to to_tag around the ring
    // both arguments are live tags in 1..rob_size
    function automatic logic [rob_tag_width-1:0] ring_dist(
        input logic [rob_tag_width-1:0] from_tag,
        input logic [rob_tag_width-1:0] to_tag
    );
        if (to_tag >= from_tag) begin
            return to_tag - from_tag;
        end
        return to_tag + rob_tag_width'(rob_size) - from_tag;
    endfunction

endpackage

`default_nettype wire

//--- design/rename_control.sv
// run/squash control; one recovery cycle per mispredict, a mispredict during squash is ignored
`timescale 1ns/1ns
`default_nettype none

module rename_control
    import rename_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  logic                     full,
    input  logic                     branch_mispredict,
    input  logic [rob_tag_width-1:0] branch_tag,
    output logic                     dispatch_ready,
    output logic                     dispatch_fire,
    output logic                     squash_active,
    output logic [rob_tag_width-1:0] squash_tag
);

    rename_state_e state;
    rename_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            run: begin
                if (branch_mispredict) begin
                    state_next = squash;
                end
            end
            // recovery lasts exactly one cycle
            squash: begin
                state_next = run;
            end
            default: begin
                state_next = run;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= run;
        end else begin
            state <= state_next;
        end
    end

    // branch tag held for the squash cycle
    always_ff @(posedge clock) begin
        if (state == run && branch_mispredict) begin
            squash_tag <= branch_tag;
        end
    end

    assign squash_active  = (state == squash);
    assign dispatch_ready = (state == run) && !full;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

endmodule

`default_nettype wire

//--- design/rob_tag_ring.sv
// tag ring for rob_size entries; retire on an empty ring is ignored, squash_tag must be live
`timescale 1ns/1ns
`default_nettype none

module rob_tag_ring
    import rename_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_fire,
    input  logic                     retire_valid,
    input  logic                     squash_active,
    input  logic [rob_tag_width-1:0] squash_tag,
    output logic [rob_tag_width-1:0] tail_tag,
    output logic [rob_tag_width-1:0] head_tag,
    output logic [rob_tag_width-1:0] rob_count,
    output logic                     full,
    output logic                     empty
);

    logic                     retire_fire;
    logic [rob_tag_width-1:0] squash_start;
    logic [rob_tag_width-1:0] squash_span;
    logic [rob_tag_width-1:0] count_next;

    assign empty = (rob_count == '0);
    assign full  = (rob_count == rob_tag_width'(rob_size));

    // oldest entry only leaves when there is one
    assign retire_fire = retire_valid && !empty;

    // squash drops everything from the branch successor up to the tail
    // when full the tail sits on the head, so the span still comes out right
    assign squash_start = next_tag(squash_tag);
    assign squash_span  = ring_dist(squash_start, tail_tag);

    always_comb begin
        count_next = rob_count;
        if (dispatch_fire) begin
            count_next = count_next + rob_tag_width'(1);
        end
        if (retire_fire) begin
            count_next = count_next - rob_tag_width'(1);
        end
        if (squash_active) begin
            count_next = count_next - squash_span;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_tag  <= rob_tag_width'(1);
            tail_tag  <= rob_tag_width'(1);
            rob_count <= '0;
        end else begin
            // control keeps dispatch low during squash
            if (dispatch_fire) begin
                tail_tag <= next_tag(tail_tag);
            end else if (squash_active) begin
                tail_tag <= squash_start;
            end
            if (retire_fire) begin
                head_tag <= next_tag(head_tag);
            end
            rob_count <= count_next;
        end
    end

endmodule

`default_nettype wire

//--- map_table/map_table.sv
// 32-entry rename map, one dispatch per cycle; register 0 is never renamed and reads tag 0
`timescale 1ns/1ns
`default_nettype none

module map_table
    import rename_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  logic                      dest_valid,
    input  logic [arch_idx_width-1:0] dest_idx,
    input  logic                      rs1_valid,
    input  logic [arch_idx_width-1:0] rs1_idx,
    input  logic                      rs2_valid,
    input  logic [arch_idx_width-1:0] rs2_idx,
    input  logic [rob_tag_width-1:0]  alloc_tag,
    input  logic                      cdb_valid,
    input  logic [rob_tag_width-1:0]  cdb_tag,
    input  logic                      retire_valid,
    input  logic [rob_tag_width-1:0]  head_tag,
    input  logic                      squash_active,
    input  logic [rob_tag_width-1:0]  squash_tag,
    input  logic [rob_tag_width-1:0]  tail_tag,
    output logic [rob_tag_width-1:0]  rs1_tag,
    output logic                      rs1_done,
    output logic [rob_tag_width-1:0]  rs2_tag,
    output logic                      rs2_done
);

    // per register: producing tag and its t_plus bit
    logic [rob_tag_width-1:0] entry_tag [num_arch_regs];
    logic [num_arch_regs-1:0] entry_done;

    logic                     write_dest;
    logic [rob_tag_width-1:0] squash_start;
    logic [rob_tag_width-1:0] squash_span;
    logic [num_arch_regs-1:0] cdb_hit;
    logic [num_arch_regs-1:0] clear_hit;

    assign write_dest = dispatch_fire && dest_valid
                        && (dest_idx != arch_idx_width'(zero_reg));

    // younger than the branch, older than the tail
    assign squash_start = next_tag(squash_tag);
    assign squash_span  = ring_dist(squash_start, tail_tag);

    always_comb begin
        for (int i = 0; i < num_arch_regs; i++) begin
            // tag 0 never matches, the value already sits in the register file
            cdb_hit[i] = cdb_valid && (entry_tag[i] != '0)
                         && (entry_tag[i] == cdb_tag);

            clear_hit[i] = 1'b0;
            if (retire_valid && (entry_tag[i] == head_tag)) begin
                clear_hit[i] = 1'b1;
            end
            if (squash_active && (entry_tag[i] != '0)
                && (ring_dist(squash_start, entry_tag[i]) < squash_span)) begin
                clear_hit[i] = 1'b1;
            end
        end
    end

    // later assignments win: completion, then clears, then the dispatch write
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_arch_regs; i++) begin
                entry_tag[i] <= '0;
            end
            entry_done <= '0;
        end else begin
            for (int i = 0; i < num_arch_regs; i++) begin
                if (cdb_hit[i]) begin
                    entry_done[i] <= 1'b1;
                end
                if (clear_hit[i]) begin
                    entry_tag[i]  <= '0;
                    entry_done[i] <= 1'b0;
                end
            end
            if (write_dest) begin
                entry_tag[dest_idx]  <= alloc_tag;
                entry_done[dest_idx] <= 1'b0;
            end
        end
    end

    // source lookup sees the table as it stood before this edge
    always_comb begin
        rs1_tag  = '0;
        rs1_done = 1'b0;
        if (rs1_valid) begin
            rs1_tag  = entry_tag[rs1_idx];
            rs1_done = entry_done[rs1_idx];
        end
    end

    always_comb begin
        rs2_tag  = '0;
        rs2_done = 1'b0;
        if (rs2_valid) begin
            rs2_tag  = entry_tag[rs2_idx];
            rs2_done = entry_done[rs2_idx];
        end
    end

endmodule

`default_nettype wire

//--- design/ooo_rename_core.sv
// rename front end, one instruction per cycle; mispredict must not share a cycle with dispatch
`timescale 1ns/1ns
`default_nettype none

module ooo_rename_core
    import rename_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,

    // dispatch side
    input  logic                      dispatch_valid,
    input  logic                      dest_valid,
    input  logic [arch_idx_width-1:0] dest_idx,
    input  logic                      rs1_valid,
    input  logic [arch_idx_width-1:0] rs1_idx,
    input  logic                      rs2_valid,
    input  logic [arch_idx_width-1:0] rs2_idx,
    output logic                      dispatch_ready,
    output logic [rob_tag_width-1:0]  alloc_tag,
    output logic [rob_tag_width-1:0]  rs1_tag,
    output logic                      rs1_done,
    output logic [rob_tag_width-1:0]  rs2_tag,
    output logic                      rs2_done,

    // completion, retirement and recovery
    input  logic                      cdb_valid,
    input  logic [rob_tag_width-1:0]  cdb_tag,
    input  logic                      retire_valid,
    input  logic                      branch_mispredict,
    input  logic [rob_tag_width-1:0]  branch_tag,
    output logic [rob_tag_width-1:0]  head_tag,
    output logic [rob_tag_width-1:0]  rob_count
);

    logic                     dispatch_fire;
    logic                     squash_active;
    logic [rob_tag_width-1:0] squash_tag;
    logic                     full;

    rename_control u_control (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .full              (full),
        .branch_mispredict (branch_mispredict),
        .branch_tag        (branch_tag),
        .dispatch_ready    (dispatch_ready),
        .dispatch_fire     (dispatch_fire),
        .squash_active     (squash_active),
        .squash_tag        (squash_tag)
    );

    // empty only gates retirement inside the ring
    rob_tag_ring u_ring (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .retire_valid  (retire_valid),
        .squash_active (squash_active),
        .squash_tag    (squash_tag),
        .tail_tag      (alloc_tag),
        .head_tag      (head_tag),
        .rob_count     (rob_count),
        .full          (full),
        .empty         ()
    );

    map_table u_map (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dest_valid    (dest_valid),
        .dest_idx      (dest_idx),
        .rs1_valid     (rs1_valid),
        .rs1_idx       (rs1_idx),
        .rs2_valid     (rs2_valid),
        .rs2_idx       (rs2_idx),
        .alloc_tag     (alloc_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .retire_valid  (retire_valid),
        .head_tag      (head_tag),
        .squash_active (squash_active),
        .squash_tag    (squash_tag),
        .tail_tag      (alloc_tag),
        .rs1_tag       (rs1_tag),
        .rs1_done      (rs1_done),
        .rs2_tag       (rs2_tag),
        .rs2_done      (rs2_done)
    );

endmodule

`default_nettype wire

//--- verif/ooo_rename_core_tb.sv
// reads verif/rename_stim.txt from the project root, one operation per cycle; register 32 = unused
`timescale 1ns/1ns
`default_nettype none

module ooo_rename_core_tb
    import rename_pkg::*;
();

    localparam int    clk_period      = 8;
    localparam int    reset_cycles    = 5;
    localparam int    watchdog_margin = 20;
    localparam int    max_ops         = 64;
    localparam int    field_count     = 12;
    localparam string stim_path       = "verif/rename_stim.txt";

    // field positions after the opcode letter
    localparam int f_dest     = 0;
    localparam int f_rs1      = 1;
    localparam int f_rs2      = 2;
    localparam int f_tag      = 3;
    localparam int f_ready    = 4;
    localparam int f_alloc    = 5;
    localparam int f_rs1_tag  = 6;
    localparam int f_rs1_done = 7;
    localparam int f_rs2_tag  = 8;
    localparam int f_rs2_done = 9;
    localparam int f_head     = 10;
    localparam int f_count    = 11;

    // opcode letters of the stim file
    localparam logic [7:0] op_dispatch   = "D";
    localparam logic [7:0] op_complete   = "C";
    localparam logic [7:0] op_retire     = "R";
    localparam logic [7:0] op_mispredict = "B";
    localparam logic [7:0] op_idle       = "N";

    logic                      clock;
    logic                      reset;
    logic                      dispatch_valid;
    logic                      dest_valid;
    logic [arch_idx_width-1:0] dest_idx;
    logic                      rs1_valid;
    logic [arch_idx_width-1:0] rs1_idx;
    logic                      rs2_valid;
    logic [arch_idx_width-1:0] rs2_idx;
    logic                      dispatch_ready;
    logic [rob_tag_width-1:0]  alloc_tag;
    logic [rob_tag_width-1:0]  rs1_tag;
    logic                      rs1_done;
    logic [rob_tag_width-1:0]  rs2_tag;
    logic                      rs2_done;
    logic                      cdb_valid;
    logic [rob_tag_width-1:0]  cdb_tag;
    logic                      retire_valid;
    logic                      branch_mispredict;
    logic [rob_tag_width-1:0]  branch_tag;
    logic [rob_tag_width-1:0]  head_tag;
    logic [rob_tag_width-1:0]  rob_count;

    logic [7:0] stim_op [max_ops];
    int         stim_field [max_ops][field_count];
    int         read_fields [field_count];
    int         stim_count  = 0;
    bit         stim_loaded = 1'b0;
    int         error_count = 0;
    int         check_count = 0;
    int         current_op  = 0;

    ooo_rename_core UUT (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dest_valid        (dest_valid),
        .dest_idx          (dest_idx),
        .rs1_valid         (rs1_valid),
        .rs1_idx           (rs1_idx),
        .rs2_valid         (rs2_valid),
        .rs2_idx           (rs2_idx),
        .dispatch_ready    (dispatch_ready),
        .alloc_tag         (alloc_tag),
        .rs1_tag           (rs1_tag),
        .rs1_done          (rs1_done),
        .rs2_tag           (rs2_tag),
        .rs2_done          (rs2_done),
        .cdb_valid         (cdb_valid),
        .cdb_tag           (cdb_tag),
        .retire_valid      (retire_valid),
        .branch_mispredict (branch_mispredict),
        .branch_tag        (branch_tag),
        .head_tag          (head_tag),
        .rob_count         (rob_count)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d (operation %0d)",
                     $time, name, actual, expected, current_op);
            error_count++;
        end
    endtask

    task automatic read_stim();
        int          fd;
        int          code;
        int          ch;
        logic [63:0] op_word;
        bit          at_end;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("error: the stim file %s cannot be opened", stim_path);
            error_count++;
            return;
        end
        at_end = 1'b0;
        while (!at_end) begin
            op_word = '0;
            code = $fscanf(fd, "%s", op_word);
            if (code != 1) begin
                at_end = 1'b1;
            end else if (op_word[7:0] == "#" && op_word[63:8] == '0) begin
                // comment line skipped up to its end
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (stim_count == max_ops) begin
                $display("error: the stim file holds more than %0d operations", max_ops);
                error_count++;
                at_end = 1'b1;
            end else begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d",
                               read_fields[0], read_fields[1], read_fields[2],
                               read_fields[3], read_fields[4], read_fields[5],
                               read_fields[6], read_fields[7], read_fields[8],
                               read_fields[9], read_fields[10], read_fields[11]);
                if (code != field_count) begin
                    $display("error: stim operation %0d is short, only %0d of %0d fields",
                             stim_count, code, field_count);
                    error_count++;
                    at_end = 1'b1;
                end else begin
                    stim_op[stim_count] = op_word[7:0];
                    for (int k = 0; k < field_count; k++) begin
                        stim_field[stim_count][k] = read_fields[k];
                    end
                    stim_count++;
                end
            end
        end
        $fclose(fd);
        if (stim_count == 0) begin
            $display("error: the stim file holds no operations");
            error_count++;
        end
    endtask

    // one stim line onto the DUT inputs for the next edge
    task automatic apply_op(input int idx);
        logic [7:0] op;
        op = stim_op[idx];
        if (op != op_dispatch && op != op_complete && op != op_retire
            && op != op_mispredict && op != op_idle) begin
            $display("error: operation %0d has an unknown opcode letter", idx);
            error_count++;
        end
        dispatch_valid    <= (op == op_dispatch);
        dest_valid        <= (stim_field[idx][f_dest] < num_arch_regs);
        dest_idx          <= arch_idx_width'(stim_field[idx][f_dest]);
        rs1_valid         <= (stim_field[idx][f_rs1] < num_arch_regs);
        rs1_idx           <= arch_idx_width'(stim_field[idx][f_rs1]);
        rs2_valid         <= (stim_field[idx][f_rs2] < num_arch_regs);
        rs2_idx           <= arch_idx_width'(stim_field[idx][f_rs2]);
        cdb_valid         <= (op == op_complete);
        cdb_tag           <= rob_tag_width'(stim_field[idx][f_tag]);
        retire_valid      <= (op == op_retire);
        branch_mispredict <= (op == op_mispredict);
        branch_tag        <= rob_tag_width'(stim_field[idx][f_tag]);
    endtask

    task automatic check_outputs(input int idx);
        check_value("dispatch_ready", dispatch_ready, stim_field[idx][f_ready]);
        check_value("alloc_tag", alloc_tag, stim_field[idx][f_alloc]);
        check_value("rs1_tag", rs1_tag, stim_field[idx][f_rs1_tag]);
        check_value("rs1_done", rs1_done, stim_field[idx][f_rs1_done]);
        check_value("rs2_tag", rs2_tag, stim_field[idx][f_rs2_tag]);
        check_value("rs2_done", rs2_done, stim_field[idx][f_rs2_done]);
        check_value("head_tag", head_tag, stim_field[idx][f_head]);
        check_value("rob_count", rob_count, stim_field[idx][f_count]);
    endtask

    initial begin
        reset             = 1'b1;
        dispatch_valid    = 1'b0;
        dest_valid        = 1'b0;
        dest_idx          = '0;
        rs1_valid         = 1'b0;
        rs1_idx           = '0;
        rs2_valid         = 1'b0;
        rs2_idx           = '0;
        cdb_valid         = 1'b0;
        cdb_tag           = '0;
        retire_valid      = 1'b0;
        branch_mispredict = 1'b0;
        branch_tag        = '0;

        read_stim();
        stim_loaded = 1'b1;

        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        // outputs sampled one ns before the edge that takes the inputs
        for (int i = 0; i < stim_count; i++) begin
            @(posedge clock);
            current_op = i;
            apply_op(i);
            #(clk_period - 1);
            check_outputs(i);
        end

        @(posedge clock);
        dispatch_valid    <= 1'b0;
        cdb_valid         <= 1'b0;
        retire_valid      <= 1'b0;
        branch_mispredict <= 1'b0;
        @(posedge clock);

        $display("%0d checks over %0d operations, %0d errors", check_count, stim_count,
                 error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // run length follows the number of operations in the stim file
    initial begin
        wait (stim_loaded);
        #((stim_count + watchdog_margin) * clk_period);
        $display("timeout: the run did not end within %0d cycles",
                 stim_count + watchdog_margin);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rename_stim.txt
# op dest rs1 rs2 tag | ready alloc rs1_tag rs1_done rs2_tag rs2_done head count
# op: D dispatch, C broadcast, R retire, B mispredict, N idle; register 32 means unused
N 32 1 2 0 1 1 0 0 0 0 1 0
D 1 32 32 0 1 1 0 0 0 0 1 0
D 2 1 32 0 1 2 1 0 0 0 1 1
D 0 2 1 0 1 3 2 0 1 0 1 2
C 32 0 1 1 1 4 0 0 1 0 1 3
N 32 1 2 0 1 4 1 1 2 0 1 3
R 32 1 32 0 1 4 1 1 0 0 1 3
N 32 1 2 0 1 4 0 0 2 0 2 2
R 32 32 32 0 1 4 0 0 0 0 2 2
R 32 32 32 0 1 4 0 0 0 0 3 1
R 32 2 32 0 1 4 0 0 0 0 4 0
D 3 32 32 0 1 4 0 0 0 0 4 0
D 4 3 32 0 1 5 4 0 0 0 4 1
D 5 32 32 0 1 6 0 0 0 0 4 2
D 6 32 32 0 1 7 0 0 0 0 4 3
D 7 32 32 0 1 8 0 0 0 0 4 4
D 8 7 32 0 1 1 8 0 0 0 4 5
D 9 32 32 0 1 2 0 0 0 0 4 6
D 10 32 32 0 1 3 0 0 0 0 4 7
D 11 10 3 0 0 4 3 0 4 0 4 8
N 32 11 10 0 0 4 0 0 3 0 4 8
C 32 3 32 4 0 4 4 0 0 0 4 8
R 32 3 32 0 0 4 4 1 0 0 4 8
N 32 3 4 0 1 4 0 0 5 0 5 7
D 12 32 32 0 1 4 0 0 0 0 5 7
R 32 4 32 0 0 5 5 0 0 0 5 8
B 32 6 7 7 1 5 7 0 8 0 6 7
N 32 7 12 0 0 5 8 0 4 0 6 7
N 32 7 6 0 1 8 0 0 7 0 6 2
D 13 5 10 0 1 8 6 0 0 0 6 2
D 14 13 9 0 1 1 8 0 0 0 6 3

//--- ooo_rename_core.f
common/rename_pkg.sv
design/rename_control.sv
design/rob_tag_ring.sv
map_table/map_table.sv
design/ooo_rename_core.sv
verif/ooo_rename_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rename front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module ooo_rename_core_tb \
    -f ooo_rename_core.f \
    -o ooo_rename_core_sim

# the stim file path is relative to the project root
./obj_dir/ooo_rename_core_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: testbench reported success"
    exit 0
else
    echo "run_sim: testbench reported failure, see sim.log"
    exit 1
fi
